/* source/lsu_pkg.sv */
package lsu_pkg;

    // data and address width
    localparam int XLEN = 32;

    // one byte enable per byte lane
    localparam int BE_W = XLEN / 8;

    // access size from the decode stage
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_t;

    // memory request flag from decode
    typedef enum logic {
        NO_REQUEST = 1'b0,
        REQUEST    = 1'b1
    } proc_req_t;

    // memory control word, 5 bits
    typedef struct packed {
        proc_req_t proc_req;
        // write enable
        logic      we;
        mem_size_t size;
        // zero extension on loads
        logic      is_unsigned;
    } mem_ctrl_t;

    // lsu transfer states
    typedef enum logic [1:0] {
        // idle, a request goes out combinationally
        WAIT_REQ   = 2'b00,
        // address phase held until gnt
        WAIT_READY = 2'b01,
        // address accepted, waiting for the response
        WAIT_VALID = 2'b10
    } lsu_state_t;

endpackage

/* source/obi_if.sv */
`timescale 1ns/10ps

interface obi_if;

    // address phase
    logic                     req;
    logic                     gnt;
    logic [lsu_pkg::XLEN-1:0] addr;
    logic                     we;
    logic [lsu_pkg::BE_W-1:0] be;
    logic [lsu_pkg::XLEN-1:0] wdata;

    // response phase
    logic                     rvalid;
    logic [lsu_pkg::XLEN-1:0] rdata;

    modport manager (
        output req, addr, we, be, wdata,
        input  gnt, rvalid, rdata
    );

    modport subordinate (
        input  req, addr, we, be, wdata,
        output gnt, rvalid, rdata
    );

endinterface

/* source/lsu.sv */
`timescale 1ns/10ps

module lsu (
    input  logic                     CLK,
    input  logic                     RSTn,
    input  lsu_pkg::mem_ctrl_t       mem_ctrl,
    input  logic                     hz_data_req,
    input  logic [lsu_pkg::XLEN-1:0] addr,
    input  logic [lsu_pkg::XLEN-1:0] wdata,
    output logic [lsu_pkg::XLEN-1:0] rdata,
    output logic                     busy,
    obi_if.manager                   obi
);

    lsu_pkg::lsu_state_t      state;
    lsu_pkg::lsu_state_t      state_next;
    logic                     req_en;
    logic [lsu_pkg::XLEN-1:0] rword;

    // access wanted by decode and allowed by the hazard unit
    assign req_en = (mem_ctrl.proc_req == lsu_pkg::REQUEST) && hz_data_req;

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            state <= lsu_pkg::WAIT_REQ;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            lsu_pkg::WAIT_REQ: begin
                if (req_en) begin
                    // gnt may already come in the request cycle
                    if (obi.gnt) begin
                        state_next = lsu_pkg::WAIT_VALID;
                    end else begin
                        state_next = lsu_pkg::WAIT_READY;
                    end
                end
            end
            lsu_pkg::WAIT_READY: begin
                if (obi.gnt) begin
                    state_next = lsu_pkg::WAIT_VALID;
                end
            end
            lsu_pkg::WAIT_VALID: begin
                if (obi.rvalid) begin
                    state_next = lsu_pkg::WAIT_REQ;
                end
            end
            default: begin
                state_next = lsu_pkg::WAIT_REQ;
            end
        endcase
    end

    // req and busy rise with the request, busy drops with rvalid
    always_comb begin
        obi.req = 1'b0;
        busy    = 1'b0;
        case (state)
            lsu_pkg::WAIT_REQ: begin
                obi.req = req_en;
                busy    = req_en;
            end
            lsu_pkg::WAIT_READY: begin
                obi.req = 1'b1;
                busy    = 1'b1;
            end
            lsu_pkg::WAIT_VALID: begin
                busy = !obi.rvalid;
            end
            default: begin
                obi.req = 1'b0;
                busy    = 1'b0;
            end
        endcase
    end

    // datapath holds these stable while busy
    assign obi.addr = addr;
    assign obi.we   = mem_ctrl.we;

    // store data replicated across lanes, be selects the live ones
    always_comb begin
        case (mem_ctrl.size)
            lsu_pkg::SIZE_BYTE: begin
                obi.wdata = {4{wdata[7:0]}};
                obi.be    = 4'b0001 << addr[1:0];
            end
            lsu_pkg::SIZE_HALF: begin
                obi.wdata = {2{wdata[15:0]}};
                obi.be    = 4'b0011 << {addr[1], 1'b0};
            end
            default: begin
                obi.wdata = wdata;
                obi.be    = 4'b1111;
            end
        endcase
    end

    // addressed lane moved down to bit 0
    assign rword = obi.rdata >> {addr[1:0], 3'b000};

    always_comb begin
        case (mem_ctrl.size)
            lsu_pkg::SIZE_BYTE: begin
                if (mem_ctrl.is_unsigned) begin
                    rdata = {24'b0, rword[7:0]};
                end else begin
                    rdata = {{24{rword[7]}}, rword[7:0]};
                end
            end
            lsu_pkg::SIZE_HALF: begin
                if (mem_ctrl.is_unsigned) begin
                    rdata = {16'b0, rword[15:0]};
                end else begin
                    rdata = {{16{rword[15]}}, rword[15:0]};
                end
            end
            default: begin
                rdata = obi.rdata;
            end
        endcase
    end

    // misaligned accesses are not supported
    a_aligned: assert property (@(posedge CLK) disable iff (!RSTn)
        obi.req |-> !(((mem_ctrl.size == lsu_pkg::SIZE_HALF) && addr[0]) ||
                      ((mem_ctrl.size == lsu_pkg::SIZE_WORD) && (addr[1:0] != 2'b00))))
        else $error("lsu: misaligned access at %h", addr);

    // address phase must not change while the memory stalls
    a_addr_stable: assert property (@(posedge CLK) disable iff (!RSTn)
        (obi.req && !obi.gnt) |=> ($stable(obi.addr) && $stable(obi.we)))
        else $error("lsu: addr or we changed before gnt");

    // a response only follows an accepted request
    a_no_stray_rvalid: assert property (@(posedge CLK) disable iff (!RSTn)
        (state == lsu_pkg::WAIT_REQ) |-> !obi.rvalid)
        else $error("lsu: rvalid with no transfer open");

endmodule

/* source/data_ram.sv */
`timescale 1ns/10ps

module data_ram #(
    parameter int MEM_WORDS   = 256,
    parameter int GNT_WAIT    = 2,
    parameter int RVALID_WAIT = 1
) (
    input  logic       CLK,
    input  logic       RSTn,
    obi_if.subordinate obi
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int GCW   = (GNT_WAIT > 0) ? $clog2(GNT_WAIT + 1) : 1;
    localparam int RCW   = (RVALID_WAIT > 0) ? $clog2(RVALID_WAIT + 1) : 1;

    logic [lsu_pkg::XLEN-1:0] mem [MEM_WORDS];
    logic [lsu_pkg::XLEN-1:0] rdata_q;
    logic [IDX_W-1:0]         idx;
    logic [GCW-1:0]           gnt_cnt;
    logic [RCW-1:0]           resp_cnt;
    logic                     resp_pend;
    logic                     accept;

    // word address, wrapped to the memory depth
    assign idx = IDX_W'((obi.addr >> 2) % MEM_WORDS);

    // no new grant while a response is still owed
    assign obi.gnt = obi.req && !resp_pend && (gnt_cnt == GCW'(GNT_WAIT));
    assign accept  = obi.req && obi.gnt;

    // counts cycles of req held without gnt
    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            gnt_cnt <= '0;
        end else if (!obi.req || accept) begin
            gnt_cnt <= '0;
        end else if (gnt_cnt != GCW'(GNT_WAIT)) begin
            gnt_cnt <= gnt_cnt + GCW'(1);
        end
    end

    // response delay, loaded on the grant
    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            resp_pend <= 1'b0;
            resp_cnt  <= '0;
        end else if (accept) begin
            resp_pend <= 1'b1;
            resp_cnt  <= RCW'(RVALID_WAIT);
        end else if (obi.rvalid) begin
            resp_pend <= 1'b0;
        end else if (resp_pend) begin
            resp_cnt <= resp_cnt - RCW'(1);
        end
    end

    // one rvalid cycle per accepted request, writes included
    assign obi.rvalid = resp_pend && (resp_cnt == '0);
    assign obi.rdata  = rdata_q;

    // array access happens in the grant cycle
    always_ff @(posedge CLK) begin
        if (accept) begin
            if (obi.we) begin
                for (int i = 0; i < lsu_pkg::BE_W; i++) begin
                    if (obi.be[i]) begin
                        mem[idx][8*i +: 8] <= obi.wdata[8*i +: 8];
                    end
                end
            end else begin
                rdata_q <= mem[idx];
            end
        end
    end

    // manager may not withdraw a stalled request
    a_req_held: assert property (@(posedge CLK) disable iff (!RSTn)
        (obi.req && !obi.gnt) |=> obi.req)
        else $error("data_ram: req dropped before gnt");

endmodule

/* source/lsu_top.sv */
`timescale 1ns/10ps

module lsu_top #(
    parameter int MEM_WORDS   = 256,
    parameter int GNT_WAIT    = 2,
    parameter int RVALID_WAIT = 1
) (
    input  logic                     CLK,
    input  logic                     RSTn,
    input  logic                     mem_req,
    input  logic                     mem_we,
    input  lsu_pkg::mem_size_t       mem_size,
    input  logic                     mem_unsigned,
    input  logic                     hz_data_req,
    input  logic [lsu_pkg::XLEN-1:0] addr,
    input  logic [lsu_pkg::XLEN-1:0] wdata,
    output logic [lsu_pkg::XLEN-1:0] rdata,
    output logic                     busy
);

    lsu_pkg::mem_ctrl_t mem_ctrl;

    // control word as the decode stage would hand it over
    assign mem_ctrl = '{
        proc_req:    lsu_pkg::proc_req_t'(mem_req),
        we:          mem_we,
        size:        mem_size,
        is_unsigned: mem_unsigned
    };

    obi_if obi ();

    lsu lsu_i (
        .CLK         (CLK),
        .RSTn        (RSTn),
        .mem_ctrl    (mem_ctrl),
        .hz_data_req (hz_data_req),
        .addr        (addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .busy        (busy),
        .obi         (obi.manager)
    );

    data_ram #(
        .MEM_WORDS   (MEM_WORDS),
        .GNT_WAIT    (GNT_WAIT),
        .RVALID_WAIT (RVALID_WAIT)
    ) data_ram_i (
        .CLK  (CLK),
        .RSTn (RSTn),
        .obi  (obi.subordinate)
    );

endmodule

/* dv/clk_gen.sv */
`timescale 1ns/10ps

module clk_gen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 16
) (
    output logic CLK,
    output logic RSTn
);

    initial begin
        CLK = 1'b0;
        forever #(HALF_PERIOD) CLK = ~CLK;
    end

    // reset released on a falling edge
    initial begin
        RSTn = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        RSTn = 1'b1;
    end

endmodule

/* dv/lsu_tb.sv */
`timescale 1ns/10ps

module lsu_tb;

    localparam int MEM_WORDS   = 256;
    localparam int GNT_WAIT    = 2;
    localparam int RVALID_WAIT = 1;
    localparam int SEED        = 32'h354380b5;
    // request cycle to rvalid cycle, counted in falling edges
    localparam int LATENCY     = GNT_WAIT + RVALID_WAIT + 1;
    localparam int ROW_CYCLES  = GNT_WAIT + RVALID_WAIT + 8;
    localparam int IDLE_CHECKS = 4;

    typedef enum int {
        OP_IDLE,
        OP_STORE,
        OP_LOAD
    } op_t;

    typedef struct {
        string                    name;
        op_t                      op;
        lsu_pkg::mem_size_t       size;
        logic                     is_unsigned;
        logic                     hz;
        logic [lsu_pkg::XLEN-1:0] addr;
        logic [lsu_pkg::XLEN-1:0] wdata;
        logic [lsu_pkg::XLEN-1:0] expected;
    } row_t;

    logic                     CLK;
    logic                     RSTn;
    logic                     mem_req;
    logic                     mem_we;
    lsu_pkg::mem_size_t       mem_size;
    logic                     mem_unsigned;
    logic                     hz_data_req;
    logic [lsu_pkg::XLEN-1:0] addr;
    logic [lsu_pkg::XLEN-1:0] wdata;
    logic [lsu_pkg::XLEN-1:0] rdata;
    logic                     busy;

    row_t                     rows[$];
    logic [lsu_pkg::XLEN-1:0] ref_mem [MEM_WORDS];
    int                       cycle_count = 0;
    int                       pass_count = 0;
    int                       fail_count = 0;
    logic                     test_ok;

    clk_gen clk_gen_i (
        .CLK  (CLK),
        .RSTn (RSTn)
    );

    lsu_top #(
        .MEM_WORDS   (MEM_WORDS),
        .GNT_WAIT    (GNT_WAIT),
        .RVALID_WAIT (RVALID_WAIT)
    ) lsu_top_i (
        .CLK          (CLK),
        .RSTn         (RSTn),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_size     (mem_size),
        .mem_unsigned (mem_unsigned),
        .hz_data_req  (hz_data_req),
        .addr         (addr),
        .wdata        (wdata),
        .rdata        (rdata),
        .busy         (busy)
    );

    function automatic int word_index(input logic [lsu_pkg::XLEN-1:0] a);
        return int'(a[lsu_pkg::XLEN-1:2]) % MEM_WORDS;
    endfunction

    function automatic int size_bytes(input lsu_pkg::mem_size_t size);
        case (size)
            lsu_pkg::SIZE_BYTE: return 1;
            lsu_pkg::SIZE_HALF: return 2;
            default: return 4;
        endcase
    endfunction

    // low bytes of wd go to consecutive lanes from addr[1:0]
    task automatic ref_store(input lsu_pkg::mem_size_t size, input logic [31:0] a,
                             input logic [31:0] wd);
        int n;
        int off;
        int w;
        n = size_bytes(size);
        off = int'(a[1:0]);
        w = word_index(a);
        for (int k = 0; k < n; k++) begin
            ref_mem[w][8*(off+k) +: 8] = wd[8*k +: 8];
        end
    endtask

    function automatic logic [31:0] ref_load(input lsu_pkg::mem_size_t size,
                                             input logic uns, input logic [31:0] a);
        logic [31:0] word;
        logic [31:0] raw;
        int          n;
        int          off;
        word = ref_mem[word_index(a)];
        n = size_bytes(size);
        off = int'(a[1:0]);
        raw = '0;
        for (int k = 0; k < n; k++) begin
            raw[8*k +: 8] = word[8*(off+k) +: 8];
        end
        // fill upper bytes with the sign of the top loaded bit
        if (!uns && raw[8*n-1]) begin
            for (int k = n; k < 4; k++) begin
                raw[8*k +: 8] = 8'hff;
            end
        end
        return raw;
    endfunction

    task automatic add_row(input string name, input op_t op, input lsu_pkg::mem_size_t size,
                           input logic uns, input logic hz, input logic [31:0] a,
                           input logic [31:0] wd);
        row_t r;
        r.name = name;
        r.op = op;
        r.size = size;
        r.is_unsigned = uns;
        r.hz = hz;
        r.addr = a;
        r.wdata = wd;
        r.expected = '0;
        if (op == OP_STORE && hz) begin
            ref_store(size, a, wd);
        end else if (op == OP_LOAD && hz) begin
            r.expected = ref_load(size, uns, a);
        end
        rows.push_back(r);
    endtask

    task automatic check_data(input string name, input logic [lsu_pkg::XLEN-1:0] expected,
                              input logic [lsu_pkg::XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_busy(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch %s busy expected %b actual %b", name, expected, actual);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_cycles(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("mismatch %s cycles expected %0d actual %0d", name, expected, actual);
            test_ok = 1'b0;
        end
    endtask

    task automatic report_test(input string name);
        $display("%-22s %s", name, test_ok ? "ok" : "error");
        if (test_ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
    endtask

    task automatic apply_row(input row_t r);
        int cycles;
        test_ok = 1'b1;
        @(negedge CLK);
        mem_req = (r.op != OP_IDLE);
        mem_we = (r.op == OP_STORE);
        mem_size = r.size;
        mem_unsigned = r.is_unsigned;
        hz_data_req = r.hz;
        addr = r.addr;
        wdata = r.wdata;
        if (r.op == OP_IDLE || !r.hz) begin
            repeat (IDLE_CHECKS) begin
                @(negedge CLK);
                check_busy(r.name, 1'b0, busy);
            end
        end else begin
            cycles = 0;
            do begin
                @(negedge CLK);
                cycles++;
            end while (busy !== 1'b0);
            // busy is low here only in the rvalid cycle
            check_cycles(r.name, LATENCY, cycles);
            if (r.op == OP_LOAD) begin
                check_data(r.name, r.expected, rdata);
            end
        end
        mem_req = 1'b0;
        hz_data_req = 1'b0;
        report_test(r.name);
    endtask

    // run limit scales with the table length
    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= rows.size() * ROW_CYCLES + 100) begin
            $display("timeout: run did not finish within %0d cycles", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        mem_req = 1'b0;
        mem_we = 1'b0;
        mem_size = lsu_pkg::SIZE_WORD;
        mem_unsigned = 1'b0;
        hz_data_req = 1'b0;
        addr = '0;
        wdata = '0;
        void'($urandom(SEED));

        add_row("idle_no_req", OP_IDLE, lsu_pkg::SIZE_WORD, 1'b0, 1'b1, 32'h0, 32'h0);
        add_row("word_store", OP_STORE, lsu_pkg::SIZE_WORD, 1'b0, 1'b1, 32'h10, $urandom);
        add_row("word_load", OP_LOAD, lsu_pkg::SIZE_WORD, 1'b0, 1'b1, 32'h10, 32'h0);
        add_row("merge_base", OP_STORE, lsu_pkg::SIZE_WORD, 1'b0, 1'b1, 32'h20, 32'h11223344);
        add_row("merge_byte1", OP_STORE, lsu_pkg::SIZE_BYTE, 1'b0, 1'b1, 32'h21, 32'h000000a5);
        add_row("merge_half1", OP_STORE, lsu_pkg::SIZE_HALF, 1'b0, 1'b1, 32'h22, 32'h0000beef);
        add_row("merge_load", OP_LOAD, lsu_pkg::SIZE_WORD, 1'b0, 1'b1, 32'h20, 32'h0);
        add_row("sign_base", OP_STORE, lsu_pkg::SIZE_WORD, 1'b0, 1'b1, 32'h30, 32'h8001ff80);
        add_row("lb_signed", OP_LOAD, lsu_pkg::SIZE_BYTE, 1'b0, 1'b1, 32'h30, 32'h0);
        add_row("lbu_unsigned", OP_LOAD, lsu_pkg::SIZE_BYTE, 1'b1, 1'b1, 32'h30, 32'h0);
        add_row("lb_lane1", OP_LOAD, lsu_pkg::SIZE_BYTE, 1'b0, 1'b1, 32'h31, 32'h0);
        add_row("lb_positive", OP_LOAD, lsu_pkg::SIZE_BYTE, 1'b0, 1'b1, 32'h32, 32'h0);
        add_row("lh_signed", OP_LOAD, lsu_pkg::SIZE_HALF, 1'b0, 1'b1, 32'h32, 32'h0);
        add_row("lhu_unsigned", OP_LOAD, lsu_pkg::SIZE_HALF, 1'b1, 1'b1, 32'h32, 32'h0);
        add_row("lhu_lane0", OP_LOAD, lsu_pkg::SIZE_HALF, 1'b1, 1'b1, 32'h30, 32'h0);
        add_row("store_blocked", OP_STORE, lsu_pkg::SIZE_WORD, 1'b0, 1'b0, 32'h10, 32'hdeadbeef);
        add_row("load_after_blocked", OP_LOAD, lsu_pkg::SIZE_WORD, 1'b0, 1'b1, 32'h10, 32'h0);
        for (int k = 0; k < 4; k++) begin
            add_row($sformatf("b2b_sb%0d", k), OP_STORE, lsu_pkg::SIZE_BYTE, 1'b0, 1'b1,
                    32'h40 + k, $urandom & 32'hff);
        end
        add_row("b2b_lh", OP_LOAD, lsu_pkg::SIZE_HALF, 1'b0, 1'b1, 32'h42, 32'h0);
        add_row("b2b_lw", OP_LOAD, lsu_pkg::SIZE_WORD, 1'b0, 1'b1, 32'h40, 32'h0);
        add_row("idle_end", OP_IDLE, lsu_pkg::SIZE_WORD, 1'b0, 1'b1, 32'h0, 32'h0);

        @(posedge RSTn);
        @(negedge CLK);
        test_ok = 1'b1;
        check_busy("reset_busy", 1'b0, busy);
        report_test("reset_busy");

        foreach (rows[i]) begin
            apply_row(rows[i]);
        end

        $display("tests %0d passed %0d failed %0d", pass_count + fail_count, pass_count,
                 fail_count);
        if (fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
source/lsu_pkg.sv
source/obi_if.sv
source/lsu.sv
source/data_ram.sv
source/lsu_top.sv
dv/clk_gen.sv
dv/lsu_tb.sv

/* Makefile */
# Verilator build and run for the lsu memory stage

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := lsu_tb
RTL_TOP   := lsu_top
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := CHECKS FAILED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "simulation ended without result"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
